/* list.f */
+incdir+design
design/pcs_pkg.sv
design/rx_gearbox.sv
design/block_lock.sv
design/descrambler.sv
design/decode_6466b.sv
design/pcs_rx.sv
verif/pcs_rx_asserts.sv
verif/pcs_rx_tb.sv

/* Makefile */
VERILATOR  := verilator
TOP        := pcs_rx_tb
FILELIST   := list.f
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Some tests failed
PASS_MSG   := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED"; \
		exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/pcs_rx_tb.sv */
`timescale 1ns/1ns
`include "pcs_macros.svh"

module pcs_rx_tb
    import pcs_pkg::*;
();

    localparam int unsigned SEED         = 32'h152a_7e5f;
    localparam int          BLOCK_CYCLES = 200;
    localparam int          LOCK_CYCLES  = `PCS_BLOCK_W * `PCS_BLOCK_W;
    localparam logic [65:0] IDLE_BLOCK   = {56'h0, BT_IDLE, HDR_CTRL};
    localparam logic [71:0] ERROR_LANES  = {8'hFF, {8{`PCS_CH_ERROR}}};
    localparam logic [7:0]  TERM_TYPE [8] = '{
        BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3, BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7
    };

    logic        rxc = 1'b0;
    logic        reset;
    logic [63:0] rxd_in;
    logic [63:0] rxd_out;
    logic [7:0]  rxctl;
    logic        rx_valid;
    logic        block_lock;

    // Transmit model queues blocks before scrambling
    logic [65:0] blk_q[$];
    logic [71:0] exp_q[$];
    bit          bit_q[$];
    logic [57:0] scr_hist;
    logic [63:0] word;
    logic [71:0] exp_lanes;
    bit          stream_on     = 1'b0;
    bit          check_en      = 1'b0;
    bit          lock_expected = 1'b0;
    int          cycles        = 0;
    int          cycle_limit   = 64;

    pcs_rx u_pcs_rx (
        .i_rxc        (rxc),
        .i_reset      (reset),
        .i_rxd        (rxd_in),
        .o_rxd        (rxd_out),
        .o_rxctl      (rxctl),
        .o_rx_valid   (rx_valid),
        .o_block_lock (block_lock)
    );

    always #4 rxc = ~rxc;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at %0t ns", $time);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("** Error at %0t ns: %s expected %h, got %h",
                                      $time, name, expected, actual));
        end
    endtask

    // Header goes out as is and the payload is scrambled by x^58 + x^39 + 1
    task automatic serialize_block(input logic [65:0] blk);
        logic s;
        bit_q.push_back(blk[0]);
        bit_q.push_back(blk[1]);
        for (int i = 2; i < 66; i++) begin
            s = blk[i] ^ scr_hist[`PCS_SCR_TAP_A-1] ^ scr_hist[`PCS_SCR_TAP_B-1];
            scr_hist = {scr_hist[56:0], s};
            bit_q.push_back(s);
        end
    endtask

    task automatic queue_block(input logic [65:0] blk, input bit expect_out,
                               input logic [71:0] lanes);
        blk_q.push_back(blk);
        if (expect_out) begin
            exp_q.push_back(lanes);
        end
        cycle_limit += BLOCK_CYCLES;
    endtask

    task automatic send_packet(input int term_lane);
        logic [7:0]  octets[$];
        logic [7:0]  oct;
        logic [63:0] pl;
        logic [63:0] xd;
        logic [7:0]  xc;
        int          len;
        len = 7 + 8 * int'($urandom_range(0, 3)) + term_lane;
        if (len < 8) begin
            len += 8;
        end
        repeat (len) octets.push_back(8'($urandom));
        // Start in lane 0 carries the first seven octets
        pl = {56'd0, BT_START0};
        for (int j = 0; j < 7; j++) begin
            pl[8+8*j +: 8] = octets.pop_front();
        end
        queue_block({pl, HDR_CTRL}, 1'b1, {8'h01, pl[63:8], `PCS_CH_START});
        while (octets.size() >= 8) begin
            for (int j = 0; j < 8; j++) begin
                pl[8*j +: 8] = octets.pop_front();
            end
            queue_block({pl, HDR_DATA}, 1'b1, {8'h00, pl});
        end
        // Leftover octets, terminate, then idle lanes
        pl = {56'd0, TERM_TYPE[term_lane]};
        xc = 8'hFF;
        for (int j = 0; j < 8; j++) begin
            if (j < term_lane) begin
                oct = octets.pop_front();
                pl = pl | (64'(oct) << (8 + 8 * j));
                xd[8*j +: 8] = oct;
                xc[j] = 1'b0;
            end else if (j == term_lane) begin
                xd[8*j +: 8] = `PCS_CH_TERM;
            end else begin
                xd[8*j +: 8] = `PCS_CH_IDLE;
            end
        end
        queue_block({pl, HDR_CTRL}, 1'b1, {xc, xd});
    endtask

    task automatic wait_for_lock();
        int seen;
        seen = 0;
        cycle_limit += LOCK_CYCLES;
        while (!block_lock) @(negedge rxc);
        lock_expected = 1'b1;
        // Descrambler history refills over the first two blocks
        while (seen < 2) begin
            @(negedge rxc);
            if (rx_valid) begin
                seen++;
            end
        end
        check_en = 1'b1;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge rxc);
    endtask

    always @(negedge rxc) begin
        if (stream_on) begin
            while (bit_q.size() < 64) begin
                if (blk_q.size() > 0) begin
                    serialize_block(blk_q.pop_front());
                end else begin
                    serialize_block(IDLE_BLOCK);
                end
            end
            for (int i = 0; i < 64; i++) begin
                word[i] = bit_q.pop_front();
            end
            rxd_in = word;
        end
    end

    // All-idle output blocks are fillers
    always @(negedge rxc) begin
        if (lock_expected) begin
            check_value("o_block_lock", 64'd1, {63'd0, block_lock});
        end
        if (check_en && rx_valid && !(rxctl == 8'hFF && rxd_out == {8{`PCS_CH_IDLE}})) begin
            if (exp_q.size() == 0) begin
                stop_with_error("Decoder produced a non-idle block that was never sent");
            end else begin
                exp_lanes = exp_q.pop_front();
                check_value("o_rxd", exp_lanes[63:0], rxd_out);
                check_value("o_rxctl", {56'd0, exp_lanes[71:64]}, {56'd0, rxctl});
            end
        end
    end

    always @(negedge rxc) begin
        if (u_pcs_rx.u_pcs_rx_asserts.fail_cnt != 0) begin
            stop_with_error("An assertion bound to pcs_rx failed");
        end
    end

    always @(posedge rxc) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            stop_with_error($sformatf("Timeout after %0d cycles, lock or output never came",
                                      cycles));
        end
    end

    initial begin
        logic [7:0]  bad_type;
        logic [63:0] pl;
        logic [1:0]  hdr;
        reset  = 1'b1;
        rxd_in = '0;
        void'($urandom(SEED));
        scr_hist = 58'({$urandom, $urandom});
        // Random bit offset ahead of the first block
        repeat ($urandom_range(0, 65)) bit_q.push_back(1'($urandom));
        repeat (8) @(posedge rxc);
        @(negedge rxc);
        reset = 1'b0;
        check_value("o_block_lock", 64'd0, {63'd0, block_lock});
        check_value("o_rx_valid", 64'd0, {63'd0, rx_valid});
        check_value("o_rxctl", 64'hFF, {56'd0, rxctl});
        check_value("o_rxd", {8{`PCS_CH_IDLE}}, rxd_out);
        stream_on = 1'b1;
        wait_for_lock();

        // Packets over every terminate lane
        for (int k = 0; k < 32; k++) begin
            send_packet(k % 8);
            repeat ($urandom_range(0, 2)) queue_block(IDLE_BLOCK, 1'b0, '0);
        end
        drain();

        // Unknown block type between two packets
        send_packet($urandom_range(0, 7));
        do begin
            bad_type = 8'($urandom);
        end while (bad_type inside {BT_IDLE, BT_START0, BT_TERM0, BT_TERM1, BT_TERM2,
                                    BT_TERM3, BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7});
        pl = {$urandom, $urandom};
        pl[7:0] = bad_type;
        queue_block({pl, HDR_CTRL}, 1'b1, ERROR_LANES);
        send_packet($urandom_range(0, 7));
        drain();

        // 15 bad headers among 64 blocks
        for (int i = 0; i < 64; i++) begin
            if (i % 4 == 0 && i < 4 * (`PCS_LOCK_BAD - 1)) begin
                hdr = ($urandom_range(0, 1) != 0) ? 2'b11 : 2'b00;
                queue_block({IDLE_BLOCK[65:2], hdr}, 1'b1, ERROR_LANES);
            end else begin
                pl = {$urandom, $urandom};
                queue_block({pl, HDR_DATA}, 1'b1, {8'h00, pl});
            end
        end
        drain();

        // Twice the limit so a burst across a window edge still drops lock
        check_en = 1'b0;
        lock_expected = 1'b0;
        repeat (2 * `PCS_LOCK_BAD) queue_block({IDLE_BLOCK[65:2], 2'b00}, 1'b0, '0);
        while (block_lock) @(negedge rxc);
        wait_for_lock();
        for (int k = 0; k < 8; k++) begin
            send_packet(k);
        end
        drain();

        if (u_pcs_rx.u_pcs_rx_asserts.fail_cnt != 0) begin
            stop_with_error("An assertion bound to pcs_rx failed");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* verif/pcs_rx_asserts.sv */
`timescale 1ns/1ns

module pcs_rx_asserts (
    input logic i_rxc,
    input logic i_reset,
    input logic i_slip,
    input logic i_gb_valid,
    input logic i_rx_valid,
    input logic i_block_lock
);

    // Number of failed assertions
    int fail_cnt = 0;

    // A locked receiver never asks the gearbox to slip
    slip_only_unlocked: assert property (
        @(posedge i_rxc) disable iff (i_reset)
        !(i_slip && i_block_lock)
    ) else begin
        fail_cnt++;
        $error("slip raised while block lock is held");
    end

    // Gearbox gap shows up at the decoder output two cycles later
    no_valid_after_gap: assert property (
        @(posedge i_rxc) disable iff (i_reset)
        !$past(i_gb_valid, 2) |-> !i_rx_valid
    ) else begin
        fail_cnt++;
        $error("o_rx_valid high two cycles after an empty gearbox cycle");
    end

    // Reset leaves the receiver unlocked and quiet
    quiet_after_reset: assert property (
        @(posedge i_rxc)
        i_reset |=> (!i_block_lock && !i_rx_valid)
    ) else begin
        fail_cnt++;
        $error("o_block_lock or o_rx_valid high right after reset");
    end

endmodule

bind pcs_rx pcs_rx_asserts u_pcs_rx_asserts (
    .i_rxc        (i_rxc),
    .i_reset      (i_reset),
    .i_slip       (slip),
    .i_gb_valid   (gb_valid),
    .i_rx_valid   (o_rx_valid),
    .i_block_lock (o_block_lock)
);

/* design/pcs_rx.sv */
`timescale 1ns/1ns
`include "pcs_macros.svh"

module pcs_rx
    import pcs_pkg::*;
#(
    parameter bit SCRAMBLER_BYPASS = 1'b0
) (
    input  logic                   i_rxc,
    input  logic                   i_reset,
    input  logic [`PCS_DATA_W-1:0] i_rxd,
    output logic [`PCS_DATA_W-1:0] o_rxd,
    output logic [7:0]             o_rxctl,
    output logic                   o_rx_valid,
    output logic                   o_block_lock
);

    logic [`PCS_BLOCK_W-1:0] gb_block;
    logic                    gb_valid;
    logic                    slip;
    sync_hdr_t               gb_header;
    logic [`PCS_DATA_W-1:0]  gb_data;

    logic                    dec_valid;
    sync_hdr_t               dec_header;
    logic [`PCS_DATA_W-1:0]  dec_data;

    // Header in the low two bits, first received
    assign gb_header = sync_hdr_t'(gb_block[1:0]);
    assign gb_data   = gb_block[`PCS_BLOCK_W-1:2];

    rx_gearbox u_rx_gearbox (
        .i_rxc   (i_rxc),
        .i_reset (i_reset),
        .i_data  (i_rxd),
        .i_slip  (slip),
        .o_block (gb_block),
        .o_valid (gb_valid)
    );

    block_lock u_block_lock (
        .i_rxc        (i_rxc),
        .i_reset      (i_reset),
        .i_header     (gb_header),
        .i_valid      (gb_valid),
        .o_slip       (slip),
        .o_block_lock (o_block_lock)
    );

    generate
        if (SCRAMBLER_BYPASS) begin : g_bypass
            // Unscrambled link, decoder takes the gearbox block directly
            assign dec_valid  = gb_valid;
            assign dec_header = gb_header;
            assign dec_data   = gb_data;
        end else begin : g_descramble
            descrambler u_descrambler (
                .i_rxc    (i_rxc),
                .i_reset  (i_reset),
                .i_valid  (gb_valid),
                .i_header (gb_header),
                .i_data   (gb_data),
                .o_valid  (dec_valid),
                .o_header (dec_header),
                .o_data   (dec_data)
            );
        end
    endgenerate

    decode_6466b u_decoder (
        .i_rxc      (i_rxc),
        .i_reset    (i_reset),
        .i_valid    (dec_valid),
        .i_header   (dec_header),
        .i_data     (dec_data),
        .o_rxd      (o_rxd),
        .o_rxctl    (o_rxctl),
        .o_rx_valid (o_rx_valid)
    );

endmodule

/* design/decode_6466b.sv */
`timescale 1ns/1ns
`include "pcs_macros.svh"

module decode_6466b
    import pcs_pkg::*;
(
    input  logic                   i_rxc,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  sync_hdr_t              i_header,
    input  logic [`PCS_DATA_W-1:0] i_data,
    output logic [`PCS_DATA_W-1:0] o_rxd,
    output logic [7:0]             o_rxctl,
    output logic                   o_rx_valid
);

    localparam int LANES = `PCS_DATA_W / 8;

    block_type_t            btype;
    logic [`PCS_DATA_W-1:0] dec_d;
    logic [LANES-1:0]       dec_c;
    logic                   dec_err;
    logic                   is_term;
    logic [2:0]             term_lane;

    assign btype = block_type_t'(i_data[7:0]);

    always_comb begin
        dec_d     = {LANES{`PCS_CH_ERROR}};
        dec_c     = '1;
        dec_err   = 1'b0;
        is_term   = 1'b0;
        term_lane = 3'd0;

        case (i_header)
            HDR_DATA: begin
                dec_d = i_data;
                dec_c = '0;
            end
            HDR_CTRL: begin
                case (btype)
                    BT_IDLE: begin
                        for (int j = 0; j < LANES; j++) begin
                            dec_d[8*j +: 8] = `PCS_CH_IDLE;
                            // 7-bit codes follow the type byte
                            if (i_data[8+7*j +: 7] != `PCS_IDLE_CODE) begin
                                dec_err = 1'b1;
                            end
                        end
                    end
                    BT_START0: begin
                        dec_d = {i_data[`PCS_DATA_W-1:8], `PCS_CH_START};
                        dec_c = 8'h01;
                    end
                    BT_TERM0: begin is_term = 1'b1; term_lane = 3'd0; end
                    BT_TERM1: begin is_term = 1'b1; term_lane = 3'd1; end
                    BT_TERM2: begin is_term = 1'b1; term_lane = 3'd2; end
                    BT_TERM3: begin is_term = 1'b1; term_lane = 3'd3; end
                    BT_TERM4: begin is_term = 1'b1; term_lane = 3'd4; end
                    BT_TERM5: begin is_term = 1'b1; term_lane = 3'd5; end
                    BT_TERM6: begin is_term = 1'b1; term_lane = 3'd6; end
                    BT_TERM7: begin is_term = 1'b1; term_lane = 3'd7; end
                    // Ordered sets and start in lane 4 land here too
                    default: dec_err = 1'b1;
                endcase
            end
            default: dec_err = 1'b1;
        endcase

        // Data up to the terminate lane, idles after it
        if (is_term) begin
            for (int j = 0; j < LANES; j++) begin
                if (j < term_lane) begin
                    dec_d[8*j +: 8] = i_data[8+8*j +: 8];
                    dec_c[j]        = 1'b0;
                end else if (j == term_lane) begin
                    dec_d[8*j +: 8] = `PCS_CH_TERM;
                end else begin
                    dec_d[8*j +: 8] = `PCS_CH_IDLE;
                    if (i_data[8+7*j +: 7] != `PCS_IDLE_CODE) begin
                        dec_err = 1'b1;
                    end
                end
            end
        end

        if (dec_err) begin
            dec_d = {LANES{`PCS_CH_ERROR}};
            dec_c = '1;
        end
    end

    always_ff @(posedge i_rxc) begin
        if (i_reset) begin
            o_rxd      <= {LANES{`PCS_CH_IDLE}};
            o_rxctl    <= '1;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= i_valid;
            if (i_valid) begin
                o_rxd   <= dec_d;
                o_rxctl <= dec_c;
            end
        end
    end

endmodule

/* design/descrambler.sv */
`timescale 1ns/1ns
`include "pcs_macros.svh"

module descrambler
    import pcs_pkg::*;
(
    input  logic                   i_rxc,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  sync_hdr_t              i_header,
    input  logic [`PCS_DATA_W-1:0] i_data,
    output logic                   o_valid,
    output sync_hdr_t              o_header,
    output logic [`PCS_DATA_W-1:0] o_data
);

    localparam int DATA_W = `PCS_DATA_W;
    localparam int TAP_A  = `PCS_SCR_TAP_A;
    localparam int TAP_B  = `PCS_SCR_TAP_B;
    localparam int HIST_W = TAP_B;

    // Received bits from earlier blocks, newest at the top
    logic [HIST_W-1:0]        hist_q;
    logic [HIST_W+DATA_W-1:0] ext;
    logic [DATA_W-1:0]        descr;

    always_comb begin
        ext = {i_data, hist_q};
        for (int i = 0; i < DATA_W; i++) begin
            descr[i] = ext[HIST_W+i] ^ ext[HIST_W+i-TAP_A] ^ ext[HIST_W+i-TAP_B];
        end
    end

    always_ff @(posedge i_rxc) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // History advances on real blocks only
    always_ff @(posedge i_rxc) begin
        if (i_valid) begin
            hist_q   <= ext[HIST_W+DATA_W-1 -: HIST_W];
            o_data   <= descr;
            o_header <= i_header;
        end
    end

endmodule

/* design/block_lock.sv */
`timescale 1ns/1ns
`include "pcs_macros.svh"

module block_lock
    import pcs_pkg::*;
(
    input  logic      i_rxc,
    input  logic      i_reset,
    input  sync_hdr_t i_header,
    input  logic      i_valid,
    output logic      o_slip,
    output logic      o_block_lock
);

    localparam int LOCK_GOOD   = `PCS_LOCK_GOOD;
    localparam int LOCK_WINDOW = `PCS_LOCK_WINDOW;
    localparam int LOCK_BAD    = `PCS_LOCK_BAD;

    typedef enum logic {
        ST_UNLOCKED,
        ST_LOCKED
    } lock_state_t;

    lock_state_t                      state;
    logic [$clog2(LOCK_GOOD)-1:0]     good_cnt;
    logic [$clog2(LOCK_WINDOW)-1:0]   win_cnt;
    logic [$clog2(LOCK_BAD+1)-1:0]    bad_cnt;
    logic [$clog2(LOCK_BAD+1)-1:0]    bad_next;
    logic                             hdr_bad;

    assign hdr_bad  = (i_header != HDR_DATA) && (i_header != HDR_CTRL);
    assign bad_next = bad_cnt + {{($bits(bad_cnt)-1){1'b0}}, hdr_bad};

    always_ff @(posedge i_rxc) begin
        if (i_reset) begin
            state    <= ST_UNLOCKED;
            good_cnt <= '0;
            win_cnt  <= '0;
            bad_cnt  <= '0;
            o_slip   <= 1'b0;
        end else begin
            o_slip <= 1'b0;
            if (i_valid) begin
                case (state)
                    ST_UNLOCKED: begin
                        if (hdr_bad) begin
                            // Wrong alignment, try the next bit
                            o_slip   <= 1'b1;
                            good_cnt <= '0;
                        end else if (good_cnt == LOCK_GOOD - 1) begin
                            state    <= ST_LOCKED;
                            good_cnt <= '0;
                            win_cnt  <= '0;
                            bad_cnt  <= '0;
                        end else begin
                            good_cnt <= good_cnt + 1'b1;
                        end
                    end
                    ST_LOCKED: begin
                        if (bad_next == LOCK_BAD) begin
                            // Too many bad headers in this window
                            state    <= ST_UNLOCKED;
                            o_slip   <= 1'b1;
                            good_cnt <= '0;
                        end else if (win_cnt == LOCK_WINDOW - 1) begin
                            win_cnt <= '0;
                            bad_cnt <= '0;
                        end else begin
                            win_cnt <= win_cnt + 1'b1;
                            bad_cnt <= bad_next;
                        end
                    end
                    default: state <= ST_UNLOCKED;
                endcase
            end
        end
    end

    assign o_block_lock = (state == ST_LOCKED);

endmodule

/* design/rx_gearbox.sv */
`timescale 1ns/1ns
`include "pcs_macros.svh"

module rx_gearbox (
    input  logic                    i_rxc,
    input  logic                    i_reset,
    input  logic [`PCS_DATA_W-1:0]  i_data,
    input  logic                    i_slip,
    output logic [`PCS_BLOCK_W-1:0] o_block,
    output logic                    o_valid
);

    localparam int DATA_W  = `PCS_DATA_W;
    localparam int BLOCK_W = `PCS_BLOCK_W;
    localparam int BUF_W   = 2 * DATA_W;
    // One stored block's worth of bits plus a fresh word
    localparam int WORK_W  = BLOCK_W + DATA_W;

    logic [BUF_W-1:0]  buf_q;
    logic [6:0]        cnt_q;
    logic              slip_armed;

    logic [WORK_W-1:0] keep_mask;
    logic [WORK_W-1:0] merged;
    logic [WORK_W-1:0] remainder;
    logic [7:0]        total;
    logic              take_slip;
    logic              emit;

    always_comb begin
        // Only one slip per emitted block
        take_slip = i_slip && slip_armed;

        // Valid buffered bits sit below cnt_q, new word goes on top
        keep_mask = ({{(WORK_W-1){1'b0}}, 1'b1} << cnt_q) - 1'b1;
        merged    = ({{(WORK_W-BUF_W){1'b0}}, buf_q} & keep_mask)
                  | ({{(WORK_W-DATA_W){1'b0}}, i_data} << cnt_q);
        total     = {1'b0, cnt_q} + 8'(DATA_W);

        // Dropping the oldest bit moves the block boundary by one
        if (take_slip) begin
            merged = merged >> 1;
            total  = total - 8'd1;
        end

        emit      = (total >= 8'(BLOCK_W));
        remainder = merged >> BLOCK_W;
    end

    // Control state
    always_ff @(posedge i_rxc) begin
        if (i_reset) begin
            cnt_q      <= '0;
            o_valid    <= 1'b0;
            slip_armed <= 1'b0;
        end else begin
            o_valid <= emit;
            if (emit) begin
                cnt_q <= 7'(total - 8'(BLOCK_W));
            end else begin
                cnt_q <= total[6:0];
            end

            if (take_slip) begin
                slip_armed <= 1'b0;
            end else if (emit) begin
                slip_armed <= 1'b1;
            end
        end
    end

    // Block and leftover bits
    always_ff @(posedge i_rxc) begin
        if (emit) begin
            o_block <= merged[BLOCK_W-1:0];
            buf_q   <= remainder[BUF_W-1:0];
        end else begin
            buf_q   <= merged[BUF_W-1:0];
        end
    end

endmodule

/* design/pcs_pkg.sv */
package pcs_pkg;

    // Sync header, 00 and 11 are invalid
    typedef enum logic [1:0] {
        HDR_DATA = 2'b01,
        HDR_CTRL = 2'b10
    } sync_hdr_t;

    // Block type field of a control block
    typedef enum logic [7:0] {
        // All control characters
        BT_IDLE   = 8'h1E,
        // Start in lane 0, then seven data octets
        BT_START0 = 8'h78,
        // Terminate after n data octets
        BT_TERM0  = 8'h87,
        BT_TERM1  = 8'h99,
        BT_TERM2  = 8'hAA,
        BT_TERM3  = 8'hB4,
        BT_TERM4  = 8'hCC,
        BT_TERM5  = 8'hD2,
        BT_TERM6  = 8'hE1,
        BT_TERM7  = 8'hFF
    } block_type_t;

endpackage

/* design/pcs_macros.svh */
`ifndef PCS_MACROS_SVH
`define PCS_MACROS_SVH

// Datapath widths
`define PCS_DATA_W      64
`define PCS_BLOCK_W     66

// Block lock thresholds
`define PCS_LOCK_GOOD   64
`define PCS_LOCK_WINDOW 64
`define PCS_LOCK_BAD    16

// Descrambler taps for x^58 + x^39 + 1
`define PCS_SCR_TAP_A   39
`define PCS_SCR_TAP_B   58

// XGMII control characters
`define PCS_CH_IDLE     8'h07
`define PCS_CH_START    8'hFB
`define PCS_CH_TERM     8'hFD
`define PCS_CH_ERROR    8'hFE
`define PCS_IDLE_CODE   7'h00

`endif
